//--- flist.f
common/timer_pkg.sv
design/timer_cmd_decoder.sv
timer_channel/timer_channel.sv
design/timer_event_collector.sv
design/timer_host.sv
verification/timer_host_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the timer host testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f flist.f \
    --top-module timer_host_tb \
    -o timer_host_sim \
    && ./obj_dir/timer_host_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }

exit 0

//--- verification/timer_host_tb.sv
/* Timer host testbench */
`timescale 1ns/1ps

module timer_host_tb;

    localparam longint timeout_cycles = 4000;

    typedef struct packed {
        logic [timer_pkg::chan_w-1:0] channel;
        logic kind;
        logic [timer_pkg::count_w-1:0] count;
        logic [63:0] cycle;                                // Expected evt_valid cycle
        logic exact;                                       // Cycle must match exactly
    } exp_event_t;

    logic clk;
    logic rst;
    logic cmd_valid;
    timer_pkg::timer_cmd_t cmd;
    logic evt_valid;
    timer_pkg::timer_event_t evt;
    logic [timer_pkg::num_channels-1:0] match_flags;

    exp_event_t expected_q[$];
    longint cycle = 0;
    string test_name = "reset";

    timer_host dut_i (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .evt_valid   (evt_valid),
        .evt         (evt),
        .match_flags (match_flags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_on_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at cycle %0d", cycle);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // Reference model of one channel from its enable command onwards
    function automatic exp_event_t predict_event(input int ch, input logic [31:0] start,
                                                 input logic [31:0] compare, input int prescale,
                                                 input longint enable_cycle, input logic exact);
        exp_event_t e;
        longint steps_match;
        longint steps_wrap;
        longint steps;
        steps_match = longint'({32'd0, compare - start});
        if (steps_match == 0) steps_match = 64'h1_0000_0000;  // Full lap needed
        steps_wrap = 64'h1_0000_0000 - longint'({32'd0, start});
        e.channel = timer_pkg::chan_w'(ch);
        e.exact = exact;
        if (steps_wrap < steps_match) begin
            steps = steps_wrap;
            e.kind = timer_pkg::kind_overflow;
            e.count = '0;
        end else begin
            steps = steps_match;
            e.kind = timer_pkg::kind_match;
            e.count = compare;
        end
        // Sampled one edge later, applied two after that, then two collector stages
        e.cycle = enable_cycle + 3 + steps * (prescale + 1) + 2;
        return e;
    endfunction

    function automatic logic [31:0] ctrl_word(input int prescale, input logic enable,
                                              input logic clear);
        timer_pkg::timer_payload_u p;
        p.value = '0;
        p.ctrl.prescale = timer_pkg::prescale_w'(prescale);
        p.ctrl.enable = enable;
        p.ctrl.clear = clear;
        return p.value;
    endfunction

    // Called 1 ns after an edge, returns 1 ns after the next one
    task automatic send_cmd(input timer_pkg::timer_op_e op, input int ch,
                            input logic [31:0] payload);
        cmd_valid = 1'b1;
        cmd.op = op;
        cmd.channel = timer_pkg::chan_w'(ch);
        cmd.payload.value = payload;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_cycles(input longint n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_for_events();
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic start_channel(input int ch, input logic [31:0] start,
                                 input logic [31:0] compare, input int prescale,
                                 input logic enable, input logic exact);
        longint enable_cycle;
        send_cmd(timer_pkg::op_control, ch, ctrl_word(0, 1'b0, 1'b1));  // Stop and clear
        send_cmd(timer_pkg::op_compare, ch, compare);
        send_cmd(timer_pkg::op_load, ch, start);
        enable_cycle = cycle;
        send_cmd(timer_pkg::op_control, ch, ctrl_word(prescale, enable, 1'b0));
        if (enable) begin
            expected_q.push_back(predict_event(ch, start, compare, prescale, enable_cycle, exact));
        end
    endtask

    // Compare every emitted event with the queue of expected events
    always @(negedge clk) begin
        int idx;
        logic lower_waiting;
        if (!rst && evt_valid) begin
            idx = -1;
            foreach (expected_q[i]) begin
                if (idx < 0 && expected_q[i].channel == evt.channel
                    && expected_q[i].kind == evt.kind) idx = i;
            end
            if (idx < 0) begin
                $display("ERROR: %s: unexpected event on channel %0d, kind %0d at cycle %0d",
                         test_name, evt.channel, evt.kind, cycle);
                stop_on_failure();
            end else begin
                check_value({test_name, " count"}, expected_q[idx].count, evt.count);
                if (expected_q[idx].exact) begin
                    check_value({test_name, " cycle"}, expected_q[idx].cycle, cycle);
                end else begin
                    check_value({test_name, " not early"}, 1, cycle >= expected_q[idx].cycle);
                end
                lower_waiting = 1'b0;
                foreach (expected_q[i]) begin
                    if (expected_q[i].channel < evt.channel
                        && expected_q[i].cycle <= expected_q[idx].cycle) lower_waiting = 1'b1;
                end
                check_value({test_name, " lower channel first"}, 0, lower_waiting);
                expected_q.delete(idx);
            end
        end
    end

    always @(negedge clk) begin
        if (cycle >= timeout_cycles) begin
            $display("ERROR: timeout at cycle %0d, %0d expected events never arrived",
                     cycle, expected_q.size());
            stop_on_failure();
        end
    end

    initial begin
        logic [31:0] cmp;
        int psc;
        longint enable_cycle;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        void'($urandom(32'h2e2a));
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_cycles(2);

        test_name = "single_match";
        cmp = 3 + $urandom % 38;
        psc = $urandom % 8;
        start_channel(0, 0, cmp, psc, 1'b1, 1'b1);
        wait_for_events();
        wait_cycles(20);                                   // No second event
        check_value("single_match flag", 1, match_flags[0]);

        // Clear while running, then the match repeats from count 0
        test_name = "clear";
        enable_cycle = cycle;
        send_cmd(timer_pkg::op_control, 0, ctrl_word(psc, 1'b1, 1'b1));
        expected_q.push_back(predict_event(0, 0, cmp, psc, enable_cycle, 1'b1));
        wait_cycles(3);
        check_value("clear flag dropped", 0, match_flags[0]);
        wait_for_events();
        check_value("clear flag after rematch", 1, match_flags[0]);

        test_name = "overflow";
        start_channel(1, 32'hffff_fffd, 32'hffff_fffd, 0, 1'b1, 1'b1);
        wait_for_events();

        test_name = "all_channels";
        for (int ch = 0; ch < timer_pkg::num_channels; ch++) begin
            cmp = 3 + $urandom % 38;
            psc = $urandom % 8;
            start_channel(ch, 0, cmp, psc, 1'b1, 1'b0);
        end
        wait_for_events();
        check_value("all_channels flags", 8'hff, match_flags);

        test_name = "disable";
        cmp = 3 + $urandom % 38;
        psc = $urandom % 8;
        start_channel(3, 0, cmp, psc, 1'b0, 1'b0);
        wait_cycles(2 * (5 + longint'(cmp) * (psc + 1)));

        if (expected_q.size() != 0) begin
            $display("ERROR: %0d expected events never arrived", expected_q.size());
            stop_on_failure();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- design/timer_host.sv
/* Multi-channel timer host */
`timescale 1ns/1ps

module timer_host (
    input  logic clk,
    input  logic rst,
    input  logic cmd_valid,
    input  timer_pkg::timer_cmd_t cmd,
    output logic evt_valid,
    output timer_pkg::timer_event_t evt,
    output logic [timer_pkg::num_channels-1:0] match_flags
);

    timer_pkg::chan_write_t chan_wr [timer_pkg::num_channels];
    timer_pkg::chan_event_t chan_events [timer_pkg::num_channels];
    logic [timer_pkg::num_channels-1:0] clear_flag;

    timer_cmd_decoder decoder_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .chan_wr    (chan_wr),
        .clear_flag (clear_flag)
    );

    // All channels count in parallel
    for (genvar g = 0; g < timer_pkg::num_channels; g++) begin : gen_chan
        timer_channel channel_i (
            .clk       (clk),
            .rst       (rst),
            .wr        (chan_wr[g]),
            .event_out (chan_events[g])
        );
    end

    timer_event_collector collector_i (
        .clk         (clk),
        .rst         (rst),
        .chan_events (chan_events),
        .clear_flag  (clear_flag),
        .evt_valid   (evt_valid),
        .evt         (evt),
        .match_flags (match_flags)
    );

endmodule

//--- design/timer_event_collector.sv
/* Timer event collector */
`timescale 1ns/1ps

module timer_event_collector (
    input  logic clk,
    input  logic rst,
    input  timer_pkg::chan_event_t chan_events [timer_pkg::num_channels],
    input  logic [timer_pkg::num_channels-1:0] clear_flag,
    output logic evt_valid,
    output timer_pkg::timer_event_t evt,
    output logic [timer_pkg::num_channels-1:0] match_flags
);

    logic [timer_pkg::num_channels-1:0] pend_match;
    logic [timer_pkg::num_channels-1:0] pend_ovf;
    logic [timer_pkg::count_w-1:0] match_cnt [timer_pkg::num_channels];
    logic [timer_pkg::count_w-1:0] ovf_cnt [timer_pkg::num_channels];
    logic sel_found;
    logic [timer_pkg::chan_w-1:0] sel_chan;
    logic sel_kind;

    // Lowest channel wins, overflow ahead of match
    always_comb begin
        sel_found = 1'b0;
        sel_chan = '0;
        sel_kind = timer_pkg::kind_match;
        for (int i = 0; i < timer_pkg::num_channels; i++) begin
            if (!sel_found && (pend_ovf[i] || pend_match[i])) begin
                sel_found = 1'b1;
                sel_chan = timer_pkg::chan_w'(i);
                sel_kind = pend_ovf[i] ? timer_pkg::kind_overflow : timer_pkg::kind_match;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_match <= '0;
            pend_ovf <= '0;
            evt_valid <= 1'b0;
            match_flags <= '0;
        end else begin
            evt_valid <= sel_found;
            if (sel_found) begin
                if (sel_kind == timer_pkg::kind_overflow) begin
                    pend_ovf[sel_chan] <= 1'b0;
                end else begin
                    pend_match[sel_chan] <= 1'b0;
                    match_flags[sel_chan] <= 1'b1;     // Sticky until cleared
                end
            end
            for (int i = 0; i < timer_pkg::num_channels; i++) begin
                if (chan_events[i].match) pend_match[i] <= 1'b1;
                if (chan_events[i].overflow) pend_ovf[i] <= 1'b1;
                if (clear_flag[i]) match_flags[i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < timer_pkg::num_channels; i++) begin
            if (chan_events[i].match) match_cnt[i] <= chan_events[i].count;
            if (chan_events[i].overflow) ovf_cnt[i] <= chan_events[i].count;
        end
        if (sel_found) begin
            evt.channel <= sel_chan;
            evt.kind <= sel_kind;
            evt.count <= (sel_kind == timer_pkg::kind_overflow) ? ovf_cnt[sel_chan]
                                                                : match_cnt[sel_chan];
        end
    end

endmodule

//--- timer_channel/timer_channel.sv
/* Single timer channel */
`timescale 1ns/1ps

module timer_channel (
    input  logic clk,
    input  logic rst,
    input  timer_pkg::chan_write_t wr,
    output timer_pkg::chan_event_t event_out
);

    logic [timer_pkg::prescale_w-1:0] prescale;
    logic [timer_pkg::prescale_w-1:0] psc_cnt;
    logic enable;
    logic [timer_pkg::count_w-1:0] compare;
    logic [timer_pkg::count_w-1:0] count;
    logic [timer_pkg::count_w-1:0] count_next;
    logic match_q;
    logic overflow_q;
    logic tick;

    assign tick = enable && (psc_cnt >= prescale);         // Prescaler terminal value
    assign count_next = count + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prescale <= '0;
            psc_cnt <= '0;
            enable <= 1'b0;
            compare <= '1;
            count <= '0;
            match_q <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            match_q <= 1'b0;
            overflow_q <= 1'b0;

            if (tick) begin
                psc_cnt <= '0;
                count <= count_next;
                match_q <= (count_next == compare);
                overflow_q <= (count == '1);               // Wrap to zero
            end else if (enable) begin
                psc_cnt <= psc_cnt + 1'b1;
            end

            if (wr.wr_compare) begin
                compare <= wr.payload.value;
            end

            // A load replaces any increment on this edge
            if (wr.wr_load) begin
                count <= wr.payload.value;
                match_q <= 1'b0;
                overflow_q <= 1'b0;
            end

            if (wr.wr_control) begin
                prescale <= wr.payload.ctrl.prescale;
                enable <= wr.payload.ctrl.enable;
                if (wr.payload.ctrl.clear) begin
                    count <= '0;
                    psc_cnt <= '0;
                    match_q <= 1'b0;
                    overflow_q <= 1'b0;
                end
            end
        end
    end

    assign event_out.match = match_q;
    assign event_out.overflow = overflow_q;
    assign event_out.count = count;                        // Holds the post-increment value

endmodule

//--- design/timer_cmd_decoder.sv
/* Timer command decoder */
`timescale 1ns/1ps

module timer_cmd_decoder (
    input  logic clk,
    input  logic rst,
    input  logic cmd_valid,
    input  timer_pkg::timer_cmd_t cmd,
    output timer_pkg::chan_write_t chan_wr [timer_pkg::num_channels],
    output logic [timer_pkg::num_channels-1:0] clear_flag
);

    logic cmd_valid_q;
    timer_pkg::timer_cmd_t cmd_q;
    logic [timer_pkg::num_channels-1:0] wr_compare_q;
    logic [timer_pkg::num_channels-1:0] wr_load_q;
    logic [timer_pkg::num_channels-1:0] wr_control_q;
    timer_pkg::timer_payload_u payload_q;

    // First stage captures the strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= cmd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            cmd_q <= cmd;
        end
        payload_q <= cmd_q.payload;                        // Shared by all channels
    end

    // Second stage decodes into per-channel strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_compare_q <= '0;
            wr_load_q <= '0;
            wr_control_q <= '0;
            clear_flag <= '0;
        end else begin
            for (int i = 0; i < timer_pkg::num_channels; i++) begin
                wr_compare_q[i] <= cmd_valid_q && cmd_q.channel == timer_pkg::chan_w'(i)
                                   && cmd_q.op == timer_pkg::op_compare;
                wr_load_q[i] <= cmd_valid_q && cmd_q.channel == timer_pkg::chan_w'(i)
                                && cmd_q.op == timer_pkg::op_load;
                wr_control_q[i] <= cmd_valid_q && cmd_q.channel == timer_pkg::chan_w'(i)
                                   && cmd_q.op == timer_pkg::op_control;
                clear_flag[i] <= cmd_valid_q && cmd_q.channel == timer_pkg::chan_w'(i)
                                 && cmd_q.op == timer_pkg::op_control
                                 && cmd_q.payload.ctrl.clear;  // Ctrl view of payload
            end
        end
    end

    always_comb begin
        for (int i = 0; i < timer_pkg::num_channels; i++) begin
            chan_wr[i].wr_compare = wr_compare_q[i];
            chan_wr[i].wr_load = wr_load_q[i];
            chan_wr[i].wr_control = wr_control_q[i];
            chan_wr[i].payload = payload_q;
        end
    end

endmodule

//--- common/timer_pkg.sv
/* Timer subsystem shared types */
package timer_pkg;

    localparam int num_channels = 8;
    localparam int chan_w = 3;            // Channel index width
    localparam int count_w = 32;          // Counter and compare width
    localparam int prescale_w = 8;

    localparam logic kind_match = 1'b0;
    localparam logic kind_overflow = 1'b1;

    typedef enum logic [1:0] {
        op_compare = 2'd0,                // Write compare value
        op_load    = 2'd1,                // Write count
        op_control = 2'd2                 // Prescale, enable, clear
    } timer_op_e;

    typedef struct packed {
        logic [21:0] reserved;
        logic clear;                      // Zero count and prescale counter
        logic enable;
        logic [prescale_w-1:0] prescale;
    } timer_ctrl_t;

    // Same payload word, seen as a count or as control fields
    typedef union packed {
        logic [count_w-1:0] value;
        timer_ctrl_t ctrl;
    } timer_payload_u;

    typedef struct packed {
        timer_op_e op;
        logic [chan_w-1:0] channel;
        timer_payload_u payload;
    } timer_cmd_t;

    typedef struct packed {
        logic wr_compare;
        logic wr_load;
        logic wr_control;
        timer_payload_u payload;
    } chan_write_t;

    typedef struct packed {
        logic match;                      // One-cycle pulse
        logic overflow;                   // One-cycle pulse, count is 0
        logic [count_w-1:0] count;
    } chan_event_t;

    typedef struct packed {
        logic [chan_w-1:0] channel;
        logic kind;                       // 0 match, 1 overflow
        logic [count_w-1:0] count;
    } timer_event_t;

endpackage
